// File: verif/eccMemStim.txt
// Columns: op addr data expData expErr, all hex
// op 0 config write, 1 write, 2 read, 3 config read, 4 write and read same address, F end
1 00 DEADBEEF 00000000 0
2 00 00000000 DEADBEEF 0
0 0 00000083 00000000 0
1 01 12345678 00000000 0
2 01 00000000 12345678 1
3 1 00000000 00000001 0
3 3 00000000 00000001 0
0 0 000000A4 00000000 0
1 02 CAFEF00D 00000000 0
2 02 00000000 CAFEF00D 1
0 0 00008A81 00000000 0
1 03 0F0F0F0F 00000000 0
2 03 00000000 0F0F0B0D 2
1 04 A5A5A5A5 00000000 0
2 04 00000000 A5A5A5A5 0
0 0 0000A685 00000000 0
1 05 00000000 00000000 0
2 05 00000000 00000020 2
3 1 00000000 00000002 0
3 2 00000000 00000002 0
3 3 00000000 00000005 0
0 1 00000000 00000000 0
3 1 00000000 00000000 0
3 2 00000000 00000002 0
4 00 11111111 DEADBEEF 0
2 00 00000000 11111111 0
3 3 00000000 00000005 0
F 00 00000000 00000000 0

// File: vlog.f
+incdir+rtl
rtl/eccPkg.sv
rtl/memPkg.sv
rtl/hsiaoEncoder.sv
rtl/hsiaoDecoder.sv
rtl/eccStorage.sv
rtl/eccCsr.sv
rtl/eccMemTop.sv
verif/eccMem_checker.sv
verif/eccMemTb.sv

// File: run.sh
#!/bin/sh
# Compile the ECC memory testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module eccMemTb -o eccMemSim
./obj_dir/eccMemSim

// File: verif/eccMemTb.sv
// Testbench for the SEC-DED protected memory, replaying operations from a stimulus file
`default_nettype none
`timescale 1ns/1ps

module eccMemTb
  import eccPkg::*;
  import memPkg::*;
();

  localparam int ClkPeriod   = 10;
  localparam int ResetCycles = 16;
  localparam int MaxOps      = 64;
  localparam int Fields      = 5;

  // Operation codes of the first column of the stimulus file
  localparam logic [3:0] OpCfgWr = 4'h0;
  localparam logic [3:0] OpMemWr = 4'h1;
  localparam logic [3:0] OpMemRd = 4'h2;
  localparam logic [3:0] OpCfgRd = 4'h3;
  localparam logic [3:0] OpWrRd  = 4'h4;
  localparam logic [3:0] OpEnd   = 4'hF;

  logic     clk_i;
  logic     arstN;
  logic     wrEn;
  addrT     wrAddr;
  dataT     wrData;
  logic     rdEn;
  addrT     rdAddr;
  logic     rdValid;
  dataT     rdData;
  eccErrT   rdErr;
  syndromeT rdSyndrome;
  logic     cfgWrEn;
  csrAddrT  cfgAddr;
  csrDataT  cfgWrData;
  csrDataT  cfgRdData;

  // Five words per operation hold op, address, data, expected data and expected status
  logic [31:0] stim [MaxOps*Fields];
  int          nOps;
  bit          loaded;

  eccMemTop uut (
    .clk_i      (clk_i),
    .arstN      (arstN),
    .wrEn       (wrEn),
    .wrAddr     (wrAddr),
    .wrData     (wrData),
    .rdEn       (rdEn),
    .rdAddr     (rdAddr),
    .rdValid    (rdValid),
    .rdData     (rdData),
    .rdErr      (rdErr),
    .rdSyndrome (rdSyndrome),
    .cfgWrEn    (cfgWrEn),
    .cfgAddr    (cfgAddr),
    .cfgWrData  (cfgWrData),
    .cfgRdData  (cfgRdData)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod/2) clk_i = ~clk_i;
  end

  // Ends the run with the reason on its own line
  task automatic stopRun(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "Run stopped");
  endtask

  task automatic reportMismatch(input string msg);
    stopRun($sformatf("ERR %0t: %s", $time, msg));
  endtask

  // Checks the result of a read one cycle after rdEn while rdValid is high
  task automatic checkRead(input int idx, input dataT expData, input eccErrT expErr);
    assert (rdValid === 1'b1) else
      reportMismatch($sformatf("op %0d: rdValid low after the read", idx));
    assert (rdData === expData) else
      reportMismatch($sformatf("op %0d: rdData %h, expected %h", idx, rdData, expData));
    assert (rdErr === expErr) else
      reportMismatch($sformatf("op %0d: rdErr %b, expected %b", idx, rdErr, expErr));
    // A clean word has a zero syndrome and a faulty one never does
    assert ((rdSyndrome == '0) == (expErr == 2'b00)) else
      reportMismatch($sformatf("op %0d: syndrome %h with status %b", idx, rdSyndrome, expErr));
  endtask

  task automatic checkCfg(input int idx, input csrDataT expData);
    assert (cfgRdData === expData) else
      reportMismatch($sformatf("op %0d: cfgRdData %h, expected %h", idx, cfgRdData, expData));
  endtask

  // Drives one operation for one cycle, entered 1 ns after a rising edge
  task automatic runOp(input int idx);
    logic [3:0]  op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expData;
    logic [31:0] expErr;
    op      = stim[idx*Fields][3:0];
    addr    = stim[idx*Fields+1];
    data    = stim[idx*Fields+2];
    expData = stim[idx*Fields+3];
    expErr  = stim[idx*Fields+4];
    case (op)
      OpCfgWr: begin
        cfgWrEn   = 1'b1;
        cfgAddr   = csrAddrT'(addr[1:0]);
        cfgWrData = data;
      end
      OpMemWr: begin
        wrEn   = 1'b1;
        wrAddr = addrT'(addr);
        wrData = data;
      end
      OpMemRd: begin
        rdEn   = 1'b1;
        rdAddr = addrT'(addr);
      end
      OpCfgRd: begin
        // Sampled after the edge so a count from the read just before is included
        cfgAddr = csrAddrT'(addr[1:0]);
      end
      OpWrRd: begin
        wrEn   = 1'b1;
        wrAddr = addrT'(addr);
        wrData = data;
        rdEn   = 1'b1;
        rdAddr = addrT'(addr);
      end
      default: stopRun($sformatf("Unknown operation code %h at stimulus line %0d", op, idx));
    endcase
    @(posedge clk_i);
    #1;
    wrEn    = 1'b0;
    rdEn    = 1'b0;
    cfgWrEn = 1'b0;
    if (op == OpMemRd || op == OpWrRd) begin
      checkRead(idx, expData, expErr[1:0]);
    end else if (op == OpCfgRd) begin
      checkCfg(idx, expData);
    end
  endtask

  initial begin
    arstN     = 1'b0;
    wrEn      = 1'b0;
    wrAddr    = '0;
    wrData    = '0;
    rdEn      = 1'b0;
    rdAddr    = '0;
    cfgWrEn   = 1'b0;
    cfgAddr   = CsrInject;
    cfgWrData = '0;
    nOps      = 0;
    // Unfilled entries read as end markers
    for (int i = 0; i < MaxOps*Fields; i++) begin
      stim[i] = 32'hF;
    end
    $readmemh("verif/eccMemStim.txt", stim);
    while (nOps < MaxOps && stim[nOps*Fields][3:0] != OpEnd) begin
      nOps++;
    end
    loaded = 1'b1;
    if (nOps == 0) begin
      stopRun("The stimulus file is missing or holds no operations");
    end
    repeat (ResetCycles) @(posedge clk_i);
    #1;
    arstN = 1'b1;
    for (int i = 0; i < nOps; i++) begin
      runOp(i);
    end
    @(posedge clk_i);
    $display("Simulation PASSED");
    $finish;
  end

  // Each operation takes one cycle so four per line leaves ample slack
  initial begin
    wait (loaded);
    #((nOps * 4 + ResetCycles) * ClkPeriod);
    stopRun("Watchdog expired before all operations finished, the run appears to hang");
  end

endmodule

`default_nettype wire

// File: verif/eccMem_checker.sv
// Concurrent checks on the read and error ports of the protected memory
`default_nettype none
`timescale 1ns/1ps

module eccMemChecker
  import eccPkg::*;
(
  input logic   clk_i,
  input logic   arstN,
  input logic   rdEn,
  input logic   rdValid,
  input eccErrT rdErr
);

  // The read register puts exactly one cycle between strobe and result
  rdValidFollowsRdEn: assert property (
    @(posedge clk_i) disable iff (!arstN) rdValid == $past(rdEn)
  ) else $error("rdValid does not follow rdEn by one cycle");

  // Single and double error flags exclude each other
  errNotBoth: assert property (
    @(posedge clk_i) disable iff (!arstN) rdValid |-> (rdErr != 2'b11)
  ) else $error("rdErr reports a single and a double error at once");

  // No result may appear while the memory is held in reset
  validLowInReset: assert property (
    @(posedge clk_i) !arstN |-> !rdValid
  ) else $error("rdValid high during reset");

endmodule

bind eccMemTop eccMemChecker uChecker (
  .clk_i   (clk_i),
  .arstN   (arstN),
  .rdEn    (rdEn),
  .rdValid (rdValid),
  .rdErr   (rdErr)
);

`default_nettype wire

// File: rtl/eccMemTop.sv
// SEC-DED protected memory joining encoder, storage, decoder and config block
`default_nettype none
`timescale 1ns/1ps

module eccMemTop
  import eccPkg::*;
  import memPkg::*;
(
  input  logic     clk_i,
  input  logic     arstN,

  // Write port
  input  logic     wrEn,
  input  addrT     wrAddr,
  input  dataT     wrData,

  // Read port, results one cycle after rdEn
  input  logic     rdEn,
  input  addrT     rdAddr,
  output logic     rdValid,
  output dataT     rdData,
  output eccErrT   rdErr,
  output syndromeT rdSyndrome,

  // Configuration port
  input  logic     cfgWrEn,
  input  csrAddrT  cfgAddr,
  input  csrDataT  cfgWrData,
  output csrDataT  cfgRdData
);

  codeT wrCode;
  codeT injectMask;
  codeT rdCode;
  addrT rdAddrQ;

  // Check bits are added on the way into the array
  hsiaoEncoder uEncoder (
    .data (wrData),
    .code (wrCode)
  );

  eccStorage uStorage (
    .clk_i      (clk_i),
    .arstN      (arstN),
    .wrEn       (wrEn),
    .wrAddr     (wrAddr),
    .wrCode     (wrCode),
    .injectMask (injectMask),
    .rdEn       (rdEn),
    .rdAddr     (rdAddr),
    .rdCode     (rdCode),
    .rdValid    (rdValid),
    .rdAddrQ    (rdAddrQ)
  );

  // Correction sits after the read register, so it adds no latency
  hsiaoDecoder uDecoder (
    .code     (rdCode),
    .data     (rdData),
    .syndrome (rdSyndrome),
    .err      (rdErr)
  );

  // Error status is logged only when rdValid qualifies it
  eccCsr uCsr (
    .clk_i      (clk_i),
    .arstN      (arstN),
    .cfgWrEn    (cfgWrEn),
    .cfgAddr    (cfgAddr),
    .cfgWrData  (cfgWrData),
    .cfgRdData  (cfgRdData),
    .wrEn       (wrEn),
    .injectMask (injectMask),
    .rdValid    (rdValid),
    .rdAddrQ    (rdAddrQ),
    .rdErr      (rdErr)
  );

endmodule

`default_nettype wire

// File: rtl/eccCsr.sv
// Configuration and status block with fault injection and error logging
`default_nettype none
`timescale 1ns/1ps

module eccCsr
  import eccPkg::*;
  import memPkg::*;
(
  input  logic    clk_i,
  input  logic    arstN,
  input  logic    cfgWrEn,
  input  csrAddrT cfgAddr,
  input  csrDataT cfgWrData,
  output csrDataT cfgRdData,
  input  logic    wrEn,
  output codeT    injectMask,
  input  logic    rdValid,
  input  addrT    rdAddrQ,
  input  eccErrT  rdErr
);

  // Inject register layout
  // Bits 5:0 and 13:8 are codeword bit indices, bits 7 and 15 their enables
  logic [5:0] injIdxA;
  logic [5:0] injIdxB;
  logic       injEnA;
  logic       injEnB;

  cntT  corrCnt;
  cntT  uncorrCnt;
  addrT lastAddr;

  logic faultyRead;

  assign faultyRead = rdValid && (|rdErr);

  // Decode the stored indices into a flip mask; indices past the codeword do
  // nothing, and two equal indices flip a single bit
  for (genvar k = 0; k < $bits(codeT); k++) begin : genMask
    assign injectMask[k] = (injEnA && (injIdxA == 6'(k))) ||
                           (injEnB && (injIdxB == 6'(k)));
  end

  // One-shot injection; a new setting wins over the clear of an old one
  always_ff @(posedge clk_i or negedge arstN) begin
    if (!arstN) begin
      injIdxA <= '0;
      injIdxB <= '0;
      injEnA  <= 1'b0;
      injEnB  <= 1'b0;
    end else if (cfgWrEn && (cfgAddr == CsrInject)) begin
      injIdxA <= cfgWrData[5:0];
      injEnA  <= cfgWrData[7];
      injIdxB <= cfgWrData[13:8];
      injEnB  <= cfgWrData[15];
    end else if (wrEn) begin
      // Consumed by this write, so the mask is gone for the next one
      injEnA <= 1'b0;
      injEnB <= 1'b0;
    end
  end

  // Counters stop at all ones; a config write of any value clears them
  always_ff @(posedge clk_i or negedge arstN) begin
    if (!arstN) begin
      corrCnt   <= '0;
      uncorrCnt <= '0;
      lastAddr  <= '0;
    end else begin
      if (cfgWrEn && (cfgAddr == CsrCorrCnt)) begin
        corrCnt <= '0;
      end else if (rdValid && rdErr[0] && (corrCnt != '1)) begin
        corrCnt <= corrCnt + 1'b1;
      end
      if (cfgWrEn && (cfgAddr == CsrUncorrCnt)) begin
        uncorrCnt <= '0;
      end else if (rdValid && rdErr[1] && (uncorrCnt != '1)) begin
        uncorrCnt <= uncorrCnt + 1'b1;
      end
      // Tracks any read that needed correction or was uncorrectable
      if (faultyRead) begin
        lastAddr <= rdAddrQ;
      end
    end
  end

  // Readback is purely combinational from the address
  always_comb begin
    cfgRdData = '0;
    case (cfgAddr)
      CsrInject:    cfgRdData[15:0] = {injEnB, 1'b0, injIdxB, injEnA, 1'b0, injIdxA};
      CsrCorrCnt:   cfgRdData[15:0] = corrCnt;
      CsrUncorrCnt: cfgRdData[15:0] = uncorrCnt;
      CsrLastAddr:  cfgRdData[$bits(addrT)-1:0] = lastAddr;
      default:      cfgRdData = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/eccStorage.sv
// Codeword array with fault injection on write and a registered read port
`default_nettype none
`timescale 1ns/1ps

`include "ecc_defs.svh"

module eccStorage
  import eccPkg::*;
  import memPkg::*;
(
  input  logic clk_i,
  input  logic arstN,
  input  logic wrEn,
  input  addrT wrAddr,
  input  codeT wrCode,
  input  codeT injectMask,
  input  logic rdEn,
  input  addrT rdAddr,
  output codeT rdCode,
  output logic rdValid,
  output addrT rdAddrQ
);

  codeT mem [`ECC_MEM_DEPTH];

  // The mask is zero unless an injection is pending, so a normal write
  // stores the codeword unchanged
  always_ff @(posedge clk_i) begin
    if (wrEn) begin
      mem[wrAddr] <= wrCode ^ injectMask;
    end
  end

  // Read data and address are sampled in the same edge as a write, so a
  // colliding read sees the word that was there before
  always_ff @(posedge clk_i) begin
    if (rdEn) begin
      rdCode  <= mem[rdAddr];
      rdAddrQ <= rdAddr;
    end
  end

  // Valid pulse lines up with the registered word one cycle after rdEn
  always_ff @(posedge clk_i or negedge arstN) begin
    if (!arstN) begin
      rdValid <= 1'b0;
    end else begin
      rdValid <= rdEn;
    end
  end

endmodule

`default_nettype wire

// File: rtl/hsiaoDecoder.sv
// Hsiao SEC-DED decoder with single-bit correction and double-bit detection
`default_nettype none
`timescale 1ns/1ps

module hsiaoDecoder
  import eccPkg::*;
(
  input  codeT     code,
  output dataT     data,
  output syndromeT syndrome,
  output eccErrT   err
);

  // Both views of the same matrix are elaboration constants
  localparam parityRowsT HsiaoRows = hsiaoCodes();
  localparam corrColsT   CorrCols  = corrCodes();

  logic singleErr;

  // A clean codeword gives an all-zero syndrome
  for (genvar i = 0; i < $bits(syndromeT); i++) begin : genSyndrome
    assign syndrome[i] = ^(code & HsiaoRows[i]);
  end

  // Flip the data bit whose column matches the syndrome
  // A check-bit error matches no data column and leaves the data untouched
  for (genvar i = 0; i < $bits(dataT); i++) begin : genCorrect
    assign data[i] = code[i] ^ (syndrome == CorrCols[i]);
  end

  // All columns have odd weight, so one flip always yields an odd syndrome
  assign singleErr = ^syndrome;

  // Two flips cancel to an even, nonzero syndrome
  // That never equals a column, so no data bit is touched in that case
  assign err[0] = singleErr;
  assign err[1] = ~singleErr & (|syndrome);

endmodule

`default_nettype wire

// File: rtl/hsiaoEncoder.sv
// Hsiao SEC-DED encoder that appends check bits to a data word
`default_nettype none
`timescale 1ns/1ps

module hsiaoEncoder
  import eccPkg::*;
(
  input  dataT data,
  output codeT code
);

  // Parity rows of the H matrix, fixed at elaboration
  localparam parityRowsT HsiaoRows = hsiaoCodes();

  syndromeT checkBits;

  // Check columns are unit vectors, so each check bit is simply the parity
  // of the data bits selected by its row
  for (genvar i = 0; i < $bits(syndromeT); i++) begin : genCheck
    assign checkBits[i] = ^(data & HsiaoRows[i][$bits(dataT)-1:0]);
  end

  // Systematic layout with the data kept in the low positions
  assign code = {checkBits, data};

endmodule

`default_nettype wire

// File: rtl/memPkg.sv
// Address and configuration register types of the protected memory
`default_nettype none

`include "ecc_defs.svh"

package memPkg;

  // Word address into the codeword array
  typedef logic [$clog2(`ECC_MEM_DEPTH)-1:0] addrT;

  // Width of the configuration data bus
  typedef logic [31:0] csrDataT;

  // Configuration register map
  // CsrInject holds two bit indices with enables, see eccCsr for the layout
  typedef enum logic [1:0] {
    CsrInject    = 2'd0,
    CsrCorrCnt   = 2'd1,
    CsrUncorrCnt = 2'd2,
    CsrLastAddr  = 2'd3
  } csrAddrT;

endpackage

`default_nettype wire

// File: rtl/eccPkg.sv
// Code types and constant functions that build the Hsiao parity-check matrix
`default_nettype none

`include "ecc_defs.svh"

package eccPkg;

  // Plain vectors for the widths that travel through the datapath
  typedef logic [`ECC_DATA_WIDTH-1:0]  dataT;
  typedef logic [`ECC_TOTAL_WIDTH-1:0] codeT;
  typedef logic [`ECC_PROT_WIDTH-1:0]  syndromeT;

  // Bit 0 flags a corrected single error, bit 1 a detected double error
  typedef logic [1:0] eccErrT;

  // Saturating event counter
  typedef logic [15:0] cntT;

  // One parity row per check bit, one bit per codeword position
  typedef logic [`ECC_PROT_WIDTH-1:0][`ECC_TOTAL_WIDTH-1:0] parityRowsT;

  // The same matrix stored column first, used to match a syndrome to a bit
  typedef logic [`ECC_TOTAL_WIDTH-1:0][`ECC_PROT_WIDTH-1:0] corrColsT;

  // Returns one entry of the H matrix
  // Data columns take the weight-3 patterns in ascending numeric order, so
  // every data column is odd, distinct and of minimum Hsiao weight
  // Check columns are unit vectors, which keeps the code systematic
  function automatic bit hsiaoMatrix(int unsigned row, int unsigned col);
    int unsigned seen;
    int unsigned weight;
    syndromeT    colCode;
    seen    = 0;
    colCode = '0;
    if (col >= `ECC_DATA_WIDTH) begin
      colCode[col-`ECC_DATA_WIDTH] = 1'b1;
    end else begin
      // 35 weight-3 patterns exist in 7 bits, enough for all 32 data columns
      for (int unsigned v = 0; v < (1 << `ECC_PROT_WIDTH); v++) begin
        weight = $countones(v);
        if (weight == 3) begin
          if (seen == col) begin
            colCode = syndromeT'(v);
          end
          seen++;
        end
      end
    end
    return colCode[row];
  endfunction

  // Row view, consumed by the parity trees of the encoder and decoder
  function automatic parityRowsT hsiaoCodes();
    parityRowsT rows;
    for (int unsigned r = 0; r < `ECC_PROT_WIDTH; r++) begin
      for (int unsigned c = 0; c < `ECC_TOTAL_WIDTH; c++) begin
        rows[r][c] = hsiaoMatrix(r, c);
      end
    end
    return rows;
  endfunction

  // Column view, i.e. the syndrome each single bit flip would produce
  function automatic corrColsT corrCodes();
    corrColsT cols;
    for (int unsigned c = 0; c < `ECC_TOTAL_WIDTH; c++) begin
      for (int unsigned r = 0; r < `ECC_PROT_WIDTH; r++) begin
        cols[c][r] = hsiaoMatrix(r, c);
      end
    end
    return cols;
  endfunction

endpackage

`default_nettype wire

// File: rtl/ecc_defs.svh
// Global sizing for the SEC-DED protected memory
`ifndef ECC_DEFS_SVH
`define ECC_DEFS_SVH

// Width of one user data word
`define ECC_DATA_WIDTH 32

// Check bits per word; 7 is the smallest count that gives SEC-DED on 32 bits
`define ECC_PROT_WIDTH 7

// Full stored codeword, data in the low bits and check bits on top
`define ECC_TOTAL_WIDTH (`ECC_DATA_WIDTH + `ECC_PROT_WIDTH)

// Number of codewords held in the storage array
`define ECC_MEM_DEPTH 64

`endif
